/* hw/id_pkg.sv */
package id_pkg;

    typedef logic [15:0] word_t;
    typedef logic [3:0]  reg_addr_t;

    // T register sits just above the eight general registers
    localparam reg_addr_t REG_T = 4'd8;

    typedef enum logic [4:0] {
        OP_NOP       = 5'b00001,
        OP_B         = 5'b00010,
        OP_BEQZ      = 5'b00100,
        OP_BNEZ      = 5'b00101,
        OP_SLL_SRA   = 5'b00110,
        OP_ADDIU3    = 5'b01000,
        OP_ADDIU     = 5'b01001,
        OP_LI        = 5'b01101,
        OP_LW        = 5'b10011,
        OP_SW        = 5'b11011,
        OP_ADDU_SUBU = 5'b11100,
        OP_LOGIC     = 5'b11101
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_SLL, ALU_SRA, ALU_ADDU, ALU_SUBU, ALU_AND, ALU_OR,
        ALU_CMP, ALU_SLTU, ALU_ADDIU, ALU_ADDIU3, ALU_LI, ALU_LW, ALU_SW,
        ALU_B, ALU_BEQZ, ALU_BNEZ, ALU_JR
    } alu_op_e;

    typedef enum logic [1:0] {MEM_NOP, MEM_READ, MEM_WRITE} mem_op_e;
    typedef enum logic [1:0] {OP1_ZERO, OP1_REG, OP1_REG_PLUS_IMM, OP1_IMM} op1_sel_e;
    typedef enum logic [1:0] {OP2_ZERO, OP2_REG, OP2_IMM} op2_sel_e;
    typedef enum logic [2:0] {BR_NONE, BR_ALWAYS, BR_EQZ, BR_NEZ, BR_REG} br_kind_e;

    // three views of the same instruction word
    typedef struct packed {
        opcode_e    op;
        logic [2:0] rx;
        logic [2:0] ry;
        logic [2:0] rz;
        logic [1:0] funct;
    } insn_rrr_t;

    typedef struct packed {
        opcode_e    op;
        logic [2:0] rx;
        logic [7:0] imm8;
    } insn_ri_t;

    typedef struct packed {
        opcode_e     op;
        logic [10:0] imm11;
    } insn_i11_t;

    typedef union packed {
        insn_rrr_t rrr;
        insn_ri_t  ri;
        insn_i11_t i11;
    } insn_u;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } fwd_t;

    typedef struct packed {
        logic      re1;
        reg_addr_t addr1;
        logic      re2;
        reg_addr_t addr2;
        op1_sel_e  op1_sel;
        op2_sel_e  op2_sel;
        word_t     imm;
        alu_op_e   alu_op;
        mem_op_e   mem_op;
        logic      wreg;
        reg_addr_t wd;
        br_kind_e  br_kind;
        word_t     br_off;
    } dec_t;

    typedef struct packed {
        word_t     operand1;
        word_t     operand2;
        alu_op_e   alu_op;
        mem_op_e   mem_op;
        logic      wreg;
        reg_addr_t wd;
    } ex_ctrl_t;

    typedef struct packed {
        logic  flag;
        word_t pc;
    } branch_t;

endpackage

/* hw/id_decoder.sv */
`timescale 1ns/1ns

module id_decoder (
    input  id_pkg::insn_u ins_i,
    output id_pkg::dec_t  dec_o
);

    id_pkg::reg_addr_t rx_a;
    id_pkg::reg_addr_t ry_a;
    id_pkg::reg_addr_t rz_a;
    id_pkg::word_t     imm8_s;
    id_pkg::word_t     imm5_s;
    id_pkg::word_t     imm4_s;
    id_pkg::word_t     imm11_s;
    id_pkg::word_t     shamt;

    assign rx_a    = {1'b0, ins_i.rrr.rx};
    assign ry_a    = {1'b0, ins_i.rrr.ry};
    assign rz_a    = {1'b0, ins_i.rrr.rz};
    assign imm8_s  = {{8{ins_i.ri.imm8[7]}}, ins_i.ri.imm8};
    assign imm5_s  = {{11{ins_i.rrr.rz[2]}}, ins_i.rrr.rz, ins_i.rrr.funct};
    assign imm4_s  = {{12{ins_i.rrr.rz[1]}}, ins_i.rrr.rz[1:0], ins_i.rrr.funct};
    assign imm11_s = {{5{ins_i.i11.imm11[10]}}, ins_i.i11.imm11};
    assign shamt   = {13'b0, ins_i.rrr.rz};

    always_comb begin
        // all-zero fields decode as NOP
        dec_o = '0;
        case (ins_i.rrr.op)
            id_pkg::OP_SLL_SRA: begin
                // funct 00 is SLL, 11 is SRA
                if (ins_i.rrr.funct[1] == ins_i.rrr.funct[0]) begin
                    dec_o.re1     = 1'b1;
                    dec_o.addr1   = ry_a;
                    dec_o.op1_sel = id_pkg::OP1_REG;
                    dec_o.op2_sel = id_pkg::OP2_IMM;
                    dec_o.imm     = shamt;
                    dec_o.alu_op  = ins_i.rrr.funct[0] ? id_pkg::ALU_SRA : id_pkg::ALU_SLL;
                    dec_o.wreg    = 1'b1;
                    dec_o.wd      = rx_a;
                end
            end
            id_pkg::OP_ADDU_SUBU: begin
                if (ins_i.rrr.funct[0]) begin
                    dec_o.re1     = 1'b1;
                    dec_o.addr1   = rx_a;
                    dec_o.re2     = 1'b1;
                    dec_o.addr2   = ry_a;
                    dec_o.op1_sel = id_pkg::OP1_REG;
                    dec_o.op2_sel = id_pkg::OP2_REG;
                    dec_o.alu_op  = ins_i.rrr.funct[1] ? id_pkg::ALU_SUBU : id_pkg::ALU_ADDU;
                    dec_o.wreg    = 1'b1;
                    dec_o.wd      = rz_a;
                end
            end
            id_pkg::OP_LOGIC: begin
                case ({ins_i.rrr.rz, ins_i.rrr.funct})
                    5'b01100, 5'b01101, 5'b01010, 5'b00011: begin
                        dec_o.re1     = 1'b1;
                        dec_o.addr1   = rx_a;
                        dec_o.re2     = 1'b1;
                        dec_o.addr2   = ry_a;
                        dec_o.op1_sel = id_pkg::OP1_REG;
                        dec_o.op2_sel = id_pkg::OP2_REG;
                        dec_o.wreg    = 1'b1;
                        dec_o.wd      = rx_a;
                        case ({ins_i.rrr.rz, ins_i.rrr.funct})
                            5'b01100: dec_o.alu_op = id_pkg::ALU_AND;
                            5'b01101: dec_o.alu_op = id_pkg::ALU_OR;
                            5'b01010: dec_o.alu_op = id_pkg::ALU_CMP;
                            default:  dec_o.alu_op = id_pkg::ALU_SLTU;
                        endcase
                        // compare results land in T
                        if (ins_i.rrr.rz != 3'b011) begin
                            dec_o.wd = id_pkg::REG_T;
                        end
                    end
                    5'b00000: begin
                        if (ins_i.rrr.ry == 3'b000) begin
                            dec_o.re1     = 1'b1;
                            dec_o.addr1   = rx_a;
                            dec_o.alu_op  = id_pkg::ALU_JR;
                            dec_o.br_kind = id_pkg::BR_REG;
                        end
                    end
                    default: ;
                endcase
            end
            id_pkg::OP_ADDIU, id_pkg::OP_ADDIU3: begin
                dec_o.re1     = 1'b1;
                dec_o.addr1   = rx_a;
                dec_o.op1_sel = id_pkg::OP1_REG;
                dec_o.op2_sel = id_pkg::OP2_IMM;
                dec_o.wreg    = 1'b1;
                if (ins_i.rrr.op == id_pkg::OP_ADDIU) begin
                    dec_o.imm    = imm8_s;
                    dec_o.alu_op = id_pkg::ALU_ADDIU;
                    dec_o.wd     = rx_a;
                end else begin
                    dec_o.imm    = imm4_s;
                    dec_o.alu_op = id_pkg::ALU_ADDIU3;
                    dec_o.wd     = ry_a;
                end
            end
            id_pkg::OP_LI: begin
                dec_o.op1_sel = id_pkg::OP1_IMM;
                dec_o.imm     = imm8_s;
                dec_o.alu_op  = id_pkg::ALU_LI;
                dec_o.wreg    = 1'b1;
                dec_o.wd      = rx_a;
            end
            id_pkg::OP_LW: begin
                dec_o.re1     = 1'b1;
                dec_o.addr1   = rx_a;
                dec_o.op1_sel = id_pkg::OP1_REG;
                dec_o.op2_sel = id_pkg::OP2_IMM;
                dec_o.imm     = imm5_s;
                dec_o.alu_op  = id_pkg::ALU_LW;
                dec_o.mem_op  = id_pkg::MEM_READ;
                dec_o.wreg    = 1'b1;
                dec_o.wd      = ry_a;
            end
            id_pkg::OP_SW: begin
                // address formed here, store data rides in operand2
                dec_o.re1     = 1'b1;
                dec_o.addr1   = rx_a;
                dec_o.re2     = 1'b1;
                dec_o.addr2   = ry_a;
                dec_o.op1_sel = id_pkg::OP1_REG_PLUS_IMM;
                dec_o.op2_sel = id_pkg::OP2_REG;
                dec_o.imm     = imm5_s;
                dec_o.alu_op  = id_pkg::ALU_SW;
                dec_o.mem_op  = id_pkg::MEM_WRITE;
            end
            id_pkg::OP_B: begin
                dec_o.alu_op  = id_pkg::ALU_B;
                dec_o.br_kind = id_pkg::BR_ALWAYS;
                dec_o.br_off  = imm11_s;
            end
            id_pkg::OP_BEQZ, id_pkg::OP_BNEZ: begin
                dec_o.re1    = 1'b1;
                dec_o.addr1  = rx_a;
                dec_o.br_off = imm8_s;
                if (ins_i.rrr.op == id_pkg::OP_BEQZ) begin
                    dec_o.alu_op  = id_pkg::ALU_BEQZ;
                    dec_o.br_kind = id_pkg::BR_EQZ;
                end else begin
                    dec_o.alu_op  = id_pkg::ALU_BNEZ;
                    dec_o.br_kind = id_pkg::BR_NEZ;
                end
            end
            default: ;
        endcase
    end

endmodule

/* hw/id_forward.sv */
`timescale 1ns/1ns

module id_forward (
    input  id_pkg::dec_t  dec_i,
    input  id_pkg::word_t reg1_data_i,
    input  id_pkg::word_t reg2_data_i,
    input  id_pkg::fwd_t  ex_fwd_i,
    input  id_pkg::fwd_t  mem_fwd_i,
    output id_pkg::word_t op1_data_o,
    output id_pkg::word_t op2_data_o
);

    // youngest result wins
    function automatic id_pkg::word_t pick(input logic re, input id_pkg::reg_addr_t addr,
                                           input id_pkg::word_t rf_data);
        id_pkg::word_t val;
        if (re && ex_fwd_i.we && ex_fwd_i.addr == addr) begin
            val = ex_fwd_i.data;
        end else if (re && mem_fwd_i.we && mem_fwd_i.addr == addr) begin
            val = mem_fwd_i.data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign op1_data_o = pick(dec_i.re1, dec_i.addr1, reg1_data_i);
    assign op2_data_o = pick(dec_i.re2, dec_i.addr2, reg2_data_i);

endmodule

/* hw/id_hazard.sv */
`timescale 1ns/1ns

module id_hazard (
    input  id_pkg::dec_t      dec_i,
    input  id_pkg::mem_op_e   last_mem_op_i,
    input  id_pkg::reg_addr_t last_wd_i,
    output logic              stall_o
);

    logic hit1;
    logic hit2;

    assign hit1 = dec_i.re1 && dec_i.addr1 == last_wd_i;
    assign hit2 = dec_i.re2 && dec_i.addr2 == last_wd_i;

    // load result not yet available for forwarding
    assign stall_o = last_mem_op_i == id_pkg::MEM_READ && (hit1 || hit2);

endmodule

/* hw/id_branch.sv */
`timescale 1ns/1ns

module id_branch (
    input  id_pkg::dec_t    dec_i,
    input  id_pkg::word_t   pc_i,
    input  id_pkg::word_t   op1_data_i,
    input  logic            stall_i,
    output id_pkg::branch_t branch_o
);

    id_pkg::word_t rel_target;
    logic          is_zero;

    assign rel_target = pc_i + 16'd1 + dec_i.br_off;
    assign is_zero    = op1_data_i == '0;

    always_comb begin
        branch_o = '0;
        case (dec_i.br_kind)
            id_pkg::BR_ALWAYS: branch_o = '{flag: 1'b1, pc: rel_target};
            id_pkg::BR_EQZ: begin
                if (is_zero) begin
                    branch_o = '{flag: 1'b1, pc: rel_target};
                end
            end
            id_pkg::BR_NEZ: begin
                if (!is_zero) begin
                    branch_o = '{flag: 1'b1, pc: rel_target};
                end
            end
            id_pkg::BR_REG: branch_o = '{flag: 1'b1, pc: op1_data_i};
            default: ;
        endcase
        // rx may still be in flight from a load
        if (stall_i) begin
            branch_o = '0;
        end
    end

endmodule

/* hw/id_ex_reg.sv */
`timescale 1ns/1ns

module id_ex_reg (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  id_pkg::dec_t      dec_i,
    input  id_pkg::word_t     op1_data_i,
    input  id_pkg::word_t     op2_data_i,
    output id_pkg::ex_ctrl_t  ex_ctrl_o,
    output id_pkg::mem_op_e   last_mem_op_o,
    output id_pkg::reg_addr_t last_wd_o
);

    id_pkg::ex_ctrl_t ex_d;
    id_pkg::ex_ctrl_t ex_q;

    always_comb begin
        case (dec_i.op1_sel)
            id_pkg::OP1_REG:          ex_d.operand1 = op1_data_i;
            id_pkg::OP1_REG_PLUS_IMM: ex_d.operand1 = op1_data_i + dec_i.imm;
            id_pkg::OP1_IMM:          ex_d.operand1 = dec_i.imm;
            default:                  ex_d.operand1 = '0;
        endcase
        case (dec_i.op2_sel)
            id_pkg::OP2_REG: ex_d.operand2 = op2_data_i;
            id_pkg::OP2_IMM: ex_d.operand2 = dec_i.imm;
            default:         ex_d.operand2 = '0;
        endcase
        ex_d.alu_op = dec_i.alu_op;
        ex_d.mem_op = dec_i.mem_op;
        ex_d.wreg   = dec_i.wreg;
        ex_d.wd     = dec_i.wd;
    end

    // all-zero word is the bubble
    always_ff @(posedge clk) begin
        if (!rst_n_i || stall_i) begin
            ex_q <= '0;
        end else begin
            ex_q <= ex_d;
        end
    end

    assign ex_ctrl_o     = ex_q;
    assign last_mem_op_o = ex_q.mem_op;
    assign last_wd_o     = ex_q.wd;

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  logic              clk,
    input  logic              rst_n_i,
    input  id_pkg::word_t     pc_i,
    input  id_pkg::insn_u     ins_i,
    input  id_pkg::word_t     reg1_data_i,
    input  id_pkg::word_t     reg2_data_i,
    input  id_pkg::fwd_t      ex_fwd_i,
    input  id_pkg::fwd_t      mem_fwd_i,
    output id_pkg::reg_addr_t reg1_addr_o,
    output logic              re1_o,
    output id_pkg::reg_addr_t reg2_addr_o,
    output logic              re2_o,
    output id_pkg::branch_t   branch_o,
    output logic              stall_o,
    output id_pkg::ex_ctrl_t  ex_ctrl_o
);

    id_pkg::dec_t      dec;
    id_pkg::word_t     op1_data;
    id_pkg::word_t     op2_data;
    id_pkg::mem_op_e   last_mem_op;
    id_pkg::reg_addr_t last_wd;
    logic              stall;

    id_decoder u_decoder (
        .ins_i (ins_i),
        .dec_o (dec)
    );

    id_forward u_forward (
        .dec_i       (dec),
        .reg1_data_i (reg1_data_i),
        .reg2_data_i (reg2_data_i),
        .ex_fwd_i    (ex_fwd_i),
        .mem_fwd_i   (mem_fwd_i),
        .op1_data_o  (op1_data),
        .op2_data_o  (op2_data)
    );

    id_hazard u_hazard (
        .dec_i         (dec),
        .last_mem_op_i (last_mem_op),
        .last_wd_i     (last_wd),
        .stall_o       (stall)
    );

    id_branch u_branch (
        .dec_i      (dec),
        .pc_i       (pc_i),
        .op1_data_i (op1_data),
        .stall_i    (stall),
        .branch_o   (branch_o)
    );

    id_ex_reg u_id_ex_reg (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall),
        .dec_i         (dec),
        .op1_data_i    (op1_data),
        .op2_data_i    (op2_data),
        .ex_ctrl_o     (ex_ctrl_o),
        .last_mem_op_o (last_mem_op),
        .last_wd_o     (last_wd)
    );

    // register file read port and fetch stall
    assign reg1_addr_o = dec.addr1;
    assign re1_o       = dec.re1;
    assign reg2_addr_o = dec.addr2;
    assign re2_o       = dec.re2;
    assign stall_o     = stall;

endmodule

/* tb/decode_stage_props.sv */
`timescale 1ns/1ns

module decode_stage_props (
    input logic             clk,
    input logic             rst_n_i,
    input logic             stall_i,
    input id_pkg::dec_t     dec_i,
    input id_pkg::ex_ctrl_t ex_ctrl_i
);

    reset_clears: assert property (@(posedge clk) !rst_n_i |=> ex_ctrl_i == '0)
        else $error("ID/EX register not cleared by reset");

    stall_bubble: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> ex_ctrl_i == '0)
        else $error("stall did not put a bubble into ID/EX");

    // bubble drops the pending load, so a held instruction goes through
    no_double_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> !(stall_i && $stable(dec_i)))
        else $error("stall repeated for the same held instruction");

endmodule

bind id_ex_reg decode_stage_props props_i (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .stall_i   (stall_i),
    .dec_i     (dec_i),
    .ex_ctrl_i (ex_ctrl_o)
);

/* tb/decode_stage_tb.sv */
`timescale 1ns/1ns

module decode_stage_tb;

    // model view of one decoded instruction
    typedef struct packed {
        logic [1:0]        rd;    // {re1, re2}
        id_pkg::reg_addr_t a1;
        id_pkg::reg_addr_t a2;
        logic [1:0]        src1;  // 0 zero, 1 reg, 2 reg+imm, 3 imm
        logic [1:0]        src2;  // 0 zero, 1 reg, 2 imm
        id_pkg::word_t     imm;   // branch offset for branches
        id_pkg::alu_op_e   alu;
        logic              wreg;
        id_pkg::reg_addr_t wd;
    } ref_t;

    logic              clk = 1'b0;
    logic              rst_n_i;
    id_pkg::word_t     pc_i;
    id_pkg::insn_u     ins_i;
    id_pkg::word_t     reg1_data_i;
    id_pkg::word_t     reg2_data_i;
    id_pkg::fwd_t      ex_fwd_i;
    id_pkg::fwd_t      mem_fwd_i;
    id_pkg::reg_addr_t reg1_addr_o;
    logic              re1_o;
    id_pkg::reg_addr_t reg2_addr_o;
    logic              re2_o;
    id_pkg::branch_t   branch_o;
    logic              stall_o;
    id_pkg::ex_ctrl_t  ex_ctrl_o;

    // eight general registers plus T
    id_pkg::word_t    rf [0:8];
    id_pkg::ex_ctrl_t exp_ex;
    logic             exp_stall;
    int               tests;
    int               checks;
    int               errors;

    decode_stage dut_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .pc_i        (pc_i),
        .ins_i       (ins_i),
        .reg1_data_i (reg1_data_i),
        .reg2_data_i (reg2_data_i),
        .ex_fwd_i    (ex_fwd_i),
        .mem_fwd_i   (mem_fwd_i),
        .reg1_addr_o (reg1_addr_o),
        .re1_o       (re1_o),
        .reg2_addr_o (reg2_addr_o),
        .re2_o       (re2_o),
        .branch_o    (branch_o),
        .stall_o     (stall_o),
        .ex_ctrl_o   (ex_ctrl_o)
    );

    always #4 clk = ~clk;

    assign reg1_data_i = (reg1_addr_o <= id_pkg::REG_T) ? rf[reg1_addr_o] : '0;
    assign reg2_data_i = (reg2_addr_o <= id_pkg::REG_T) ? rf[reg2_addr_o] : '0;

    task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic ref_t make_ref(input id_pkg::alu_op_e alu, input logic [1:0] rd,
                                      input id_pkg::reg_addr_t a1, input id_pkg::reg_addr_t a2,
                                      input logic [3:0] src, input id_pkg::word_t imm,
                                      input logic [4:0] wr);
        ref_t r;
        r.rd   = rd;
        r.a1   = a1;
        r.a2   = a2;
        r.src1 = src[3:2];
        r.src2 = src[1:0];
        r.imm  = imm;
        r.alu  = alu;
        r.wreg = wr[4];
        r.wd   = wr[3:0];
        return r;
    endfunction

    function automatic ref_t decode_ref(input id_pkg::word_t w);
        id_pkg::reg_addr_t rx;
        id_pkg::reg_addr_t ry;
        id_pkg::reg_addr_t rz;
        ref_t              r;
        rx = {1'b0, w[10:8]};
        ry = {1'b0, w[7:5]};
        rz = {1'b0, w[4:2]};
        r  = '0;
        case (w[15:11])
            5'b00110: if (w[1] == w[0])
                r = make_ref(w[0] ? id_pkg::ALU_SRA : id_pkg::ALU_SLL, 2'b10, ry, '0,
                             4'b0110, {13'b0, w[4:2]}, {1'b1, rx});
            5'b11100: if (w[0])
                r = make_ref(w[1] ? id_pkg::ALU_SUBU : id_pkg::ALU_ADDU, 2'b11, rx, ry,
                             4'b0101, '0, {1'b1, rz});
            5'b11101: case (w[4:0])
                5'b01100: r = make_ref(id_pkg::ALU_AND, 2'b11, rx, ry, 4'b0101, '0, {1'b1, rx});
                5'b01101: r = make_ref(id_pkg::ALU_OR, 2'b11, rx, ry, 4'b0101, '0, {1'b1, rx});
                5'b01010: r = make_ref(id_pkg::ALU_CMP, 2'b11, rx, ry, 4'b0101, '0,
                                       {1'b1, id_pkg::REG_T});
                5'b00011: r = make_ref(id_pkg::ALU_SLTU, 2'b11, rx, ry, 4'b0101, '0,
                                       {1'b1, id_pkg::REG_T});
                5'b00000: if (w[7:5] == 3'b000)
                    r = make_ref(id_pkg::ALU_JR, 2'b10, rx, '0, 4'b0000, '0, 5'd0);
                default: ;
            endcase
            5'b01001: r = make_ref(id_pkg::ALU_ADDIU, 2'b10, rx, '0, 4'b0110,
                                   16'($signed(w[7:0])), {1'b1, rx});
            5'b01000: r = make_ref(id_pkg::ALU_ADDIU3, 2'b10, rx, '0, 4'b0110,
                                   16'($signed(w[3:0])), {1'b1, ry});
            5'b01101: r = make_ref(id_pkg::ALU_LI, 2'b00, '0, '0, 4'b1100,
                                   16'($signed(w[7:0])), {1'b1, rx});
            5'b10011: r = make_ref(id_pkg::ALU_LW, 2'b10, rx, '0, 4'b0110,
                                   16'($signed(w[4:0])), {1'b1, ry});
            5'b11011: r = make_ref(id_pkg::ALU_SW, 2'b11, rx, ry, 4'b1001,
                                   16'($signed(w[4:0])), 5'd0);
            5'b00010: r = make_ref(id_pkg::ALU_B, 2'b00, '0, '0, 4'b0000,
                                   16'($signed(w[10:0])), 5'd0);
            5'b00100: r = make_ref(id_pkg::ALU_BEQZ, 2'b10, rx, '0, 4'b0000,
                                   16'($signed(w[7:0])), 5'd0);
            5'b00101: r = make_ref(id_pkg::ALU_BNEZ, 2'b10, rx, '0, 4'b0000,
                                   16'($signed(w[7:0])), 5'd0);
            default: ;
        endcase
        return r;
    endfunction

    function automatic id_pkg::word_t forward_ref(input logic re, input id_pkg::reg_addr_t a);
        id_pkg::word_t v;
        v = rf[a];
        if (re && mem_fwd_i.we && mem_fwd_i.addr == a) begin
            v = mem_fwd_i.data;
        end
        // EX is younger and overrides MEM
        if (re && ex_fwd_i.we && ex_fwd_i.addr == a) begin
            v = ex_fwd_i.data;
        end
        return v;
    endfunction

    function automatic id_pkg::word_t rand_insn();
        id_pkg::word_t w;
        w = 16'($urandom);
        case ($urandom_range(0, 14))
            0: begin
                w[15:11] = 5'b00110;
                w[1]     = w[0];
            end
            1: begin
                w[15:11] = 5'b11100;
                w[0]     = 1'b1;
            end
            2: begin
                w[15:11] = 5'b11101;
                case ($urandom_range(0, 3))
                    0: w[4:0] = 5'b01100;
                    1: w[4:0] = 5'b01101;
                    2: w[4:0] = 5'b01010;
                    default: w[4:0] = 5'b00011;
                endcase
            end
            3: begin
                w[15:11] = 5'b11101;
                w[7:0]   = 8'h00;
            end
            4: w[15:11] = 5'b01001;
            5: w[15:11] = 5'b01000;
            6: w[15:11] = 5'b01101;
            7: w[15:11] = 5'b10011;
            8: w[15:11] = 5'b11011;
            9: w[15:11] = 5'b00010;
            10: w[15:11] = 5'b00100;
            11: w[15:11] = 5'b00101;
            12: w[15:11] = 5'b00001;
            // raw word, mostly undecoded opcodes
            default: ;
        endcase
        return w;
    endfunction

    task automatic drive_side(input id_pkg::word_t ins);
        int idx;
        ex_fwd_i.we    = 1'($urandom);
        ex_fwd_i.addr  = {1'b0, ($urandom_range(0, 1) == 1) ? ins[10:8] : ins[7:5]};
        ex_fwd_i.data  = 16'($urandom);
        mem_fwd_i.we   = 1'($urandom);
        mem_fwd_i.addr = {1'b0, ($urandom_range(0, 2) == 0) ? ins[7:5] : ins[10:8]};
        mem_fwd_i.data = ($urandom_range(0, 7) == 0) ? '0 : 16'($urandom);
        idx = $urandom_range(0, 8);
        rf[idx] = ($urandom_range(0, 3) == 0) ? '0 : 16'($urandom);
    endtask

    task automatic run_cycle(input id_pkg::word_t ins, input id_pkg::word_t pc);
        ref_t             r;
        id_pkg::word_t    v1;
        id_pkg::word_t    v2;
        id_pkg::ex_ctrl_t nxt;
        id_pkg::branch_t  br;
        @(posedge clk);
        #1;
        check_val(64'(ex_ctrl_o), 64'(exp_ex), "ex_ctrl");
        ins_i = ins;
        pc_i  = pc;
        drive_side(ins);
        #3;
        r  = decode_ref(ins);
        v1 = forward_ref(r.rd[1], r.a1);
        v2 = forward_ref(r.rd[0], r.a2);
        exp_stall = exp_ex.mem_op == id_pkg::MEM_READ &&
                    ((r.rd[1] && r.a1 == exp_ex.wd) || (r.rd[0] && r.a2 == exp_ex.wd));
        case (r.src1)
            2'd1: nxt.operand1 = v1;
            2'd2: nxt.operand1 = v1 + r.imm;
            2'd3: nxt.operand1 = r.imm;
            default: nxt.operand1 = '0;
        endcase
        nxt.operand2 = (r.src2 == 2'd1) ? v2 : (r.src2 == 2'd2) ? r.imm : '0;
        nxt.alu_op   = r.alu;
        nxt.mem_op   = (r.alu == id_pkg::ALU_LW) ? id_pkg::MEM_READ :
                       (r.alu == id_pkg::ALU_SW) ? id_pkg::MEM_WRITE : id_pkg::MEM_NOP;
        nxt.wreg     = r.wreg;
        nxt.wd       = r.wd;
        br = '0;
        case (r.alu)
            id_pkg::ALU_B:    br = '{flag: 1'b1, pc: pc + 16'd1 + r.imm};
            id_pkg::ALU_BEQZ: if (v1 == '0) br = '{flag: 1'b1, pc: pc + 16'd1 + r.imm};
            id_pkg::ALU_BNEZ: if (v1 != '0) br = '{flag: 1'b1, pc: pc + 16'd1 + r.imm};
            id_pkg::ALU_JR:   br = '{flag: 1'b1, pc: v1};
            default: ;
        endcase
        if (exp_stall) begin
            br = '0;
        end
        check_val(64'(reg1_addr_o), 64'(r.a1), "reg1_addr");
        check_val(64'(re1_o), 64'(r.rd[1]), "re1");
        check_val(64'(reg2_addr_o), 64'(r.a2), "reg2_addr");
        check_val(64'(re2_o), 64'(r.rd[0]), "re2");
        check_val(64'(stall_o), 64'(exp_stall), "stall");
        check_val(64'(branch_o), 64'(br), "branch");
        exp_ex = exp_stall ? '0 : nxt;
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        $display("test %s done, %0d errors", name, errors - errors_before);
    endtask

    task automatic apply_reset();
        int e0;
        e0 = errors;
        rst_n_i = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        #3;
        check_val(64'(ex_ctrl_o), 64'd0, "ex_ctrl after reset");
        check_val(64'(stall_o), 64'd0, "stall after reset");
        check_val(64'(branch_o.flag), 64'd0, "branch flag after reset");
        report_test("reset", e0);
    endtask

    task automatic run_random(input int n);
        int            e0;
        int            i;
        id_pkg::word_t ins;
        id_pkg::word_t pc;
        e0  = errors;
        ins = 16'h0800;
        pc  = '0;
        for (i = 0; i < n; i++) begin
            // fetch holds the instruction while stalled
            if (!exp_stall) begin
                ins = rand_insn();
                pc  = 16'($urandom);
            end
            run_cycle(ins, pc);
        end
        report_test("random", e0);
    endtask

    task automatic run_load_use();
        int e0;
        int waited;
        e0 = errors;
        run_cycle(16'h0800, 16'h0040);
        // LW r3, 2(r1) then BEQZ r3
        run_cycle({5'b10011, 3'd1, 3'd3, 5'd2}, 16'h0041);
        run_cycle({5'b00100, 3'd3, 8'h05}, 16'h0042);
        assert (stall_o) else begin
            errors++;
            $display("load followed by a dependent branch did not stall");
        end
        waited = 0;
        while (stall_o && waited < 4) begin
            run_cycle({5'b00100, 3'd3, 8'h05}, 16'h0042);
            waited++;
        end
        if (stall_o) begin
            errors++;
            $display("timeout: held branch still stalled after 4 cycles");
        end
        run_cycle(16'h0800, 16'h0043);
        report_test("load_use", e0);
    endtask

    initial begin
        rst_n_i   = 1'b0;
        pc_i      = '0;
        ins_i     = 16'h0800;
        ex_fwd_i  = '0;
        mem_fwd_i = '0;
        exp_ex    = '0;
        exp_stall = 1'b0;
        tests     = 0;
        checks    = 0;
        errors    = 0;
        void'($urandom(32'hd04bc224));
        for (int k = 0; k <= 8; k++) begin
            rf[k] = 16'($urandom);
        end
        apply_reset();
        run_random(400);
        run_load_use();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
hw/id_pkg.sv
hw/id_decoder.sv
hw/id_forward.sv
hw/id_hazard.sv
hw/id_branch.sv
hw/id_ex_reg.sv
hw/decode_stage.sv
tb/decode_stage_props.sv
tb/decode_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(EXE) | tee $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
